// File: hdl/l2_pkg.sv
// ************************************************************************
// L2 cache shared definitions
// ************************************************************************

`default_nettype none

package l2_pkg;

    // address and data widths
    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;

    // line geometry
    localparam int WORDS_PER_LINE = 4;
    localparam int OFFSET_BITS = 4;
    localparam int WORD_OFF_BITS = 2;

    // associativity, the lookup and victim logic assume two ways
    localparam int N_WAYS = 2;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [WORD_W-1:0] word_t;

    // word 0 sits in the low bits of the line
    typedef word_t [WORDS_PER_LINE-1:0] line_t;

    typedef enum logic [1:0] {
        LINE_INVALID,
        LINE_CLEAN,
        LINE_DIRTY
    } line_state_t;

    typedef enum logic {
        OP_READ,
        OP_WRITE
    } cpu_op_t;

    typedef enum logic {
        MEM_FILL,
        MEM_WRITEBACK
    } mem_op_t;

    // controller states
    typedef enum logic [3:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_HIT,
        ST_WB_REQ,
        ST_WB_WAIT,
        ST_FILL_REQ,
        ST_FILL_WAIT,
        ST_ACK,
        ST_ACK_WAIT
    } l2_fsm_state_t;

endpackage

`default_nettype wire

// File: hdl/l2_input_decoder.sv
// ************************************************************************
// L2 CPU request decoder
// ************************************************************************

`timescale 1ns/100ps
`default_nettype none

module l2_input_decoder #(
    parameter int SET_BITS = 4,
    localparam int TAG_W = l2_pkg::ADDR_W - SET_BITS - l2_pkg::OFFSET_BITS
) (
    input  logic                             clk,
    input  logic                             rst_n_i,
    input  logic                             cpu_req_i,
    input  l2_pkg::cpu_op_t                  cpu_op_i,
    input  l2_pkg::addr_t                    cpu_addr_i,
    input  l2_pkg::word_t                    cpu_wdata_i,
    input  logic                             busy_i,
    output logic                             decode_valid_o,
    output l2_pkg::cpu_op_t                  req_op_o,
    output logic [TAG_W-1:0]                 req_tag_o,
    output logic [SET_BITS-1:0]              req_set_o,
    output logic [l2_pkg::WORD_OFF_BITS-1:0] req_woff_o,
    output l2_pkg::word_t                    req_wdata_o
);

    // set once a request is taken, cleared when req drops
    logic taken_q;
    logic take;

    assign take = cpu_req_i && !taken_q && !busy_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            taken_q        <= 1'b0;
            decode_valid_o <= 1'b0;
            req_set_o      <= '0;
        end else begin
            decode_valid_o <= take;
            if (take) begin
                taken_q   <= 1'b1;
                req_set_o <= cpu_addr_i[l2_pkg::OFFSET_BITS +: SET_BITS];
            end else if (!cpu_req_i) begin
                taken_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            req_op_o    <= cpu_op_i;
            req_tag_o   <= cpu_addr_i[l2_pkg::ADDR_W-1 -: TAG_W];
            req_woff_o  <= cpu_addr_i[l2_pkg::OFFSET_BITS-1 -: l2_pkg::WORD_OFF_BITS];
            req_wdata_o <= cpu_wdata_i;
        end
    end

    // four-phase protocol keeps the address steady for the whole request
    addr_stable_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        cpu_req_i ##1 cpu_req_i |-> $stable(cpu_addr_i));

endmodule

`default_nettype wire

// File: hdl/l2_localmem.sv
// ************************************************************************
// L2 tag, state and data arrays
// ************************************************************************

`timescale 1ns/100ps
`default_nettype none

module l2_localmem #(
    parameter int SET_BITS = 4,
    localparam int TAG_W = l2_pkg::ADDR_W - SET_BITS - l2_pkg::OFFSET_BITS,
    localparam int SETS = 2 ** SET_BITS
) (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic [SET_BITS-1:0] rd_set_i,
    input  logic                wr_en_i,
    input  logic                wr_way_i,
    input  logic [SET_BITS-1:0] wr_set_i,
    input  logic [TAG_W-1:0]    wr_tag_i,
    input  l2_pkg::line_state_t wr_state_i,
    input  l2_pkg::line_t       wr_line_i,
    output logic [TAG_W-1:0]    rd_tag_o [l2_pkg::N_WAYS],
    output l2_pkg::line_state_t rd_state_o [l2_pkg::N_WAYS],
    output l2_pkg::line_t       rd_line_o [l2_pkg::N_WAYS],
    output logic                init_done_o
);

    logic [TAG_W-1:0]    tag_mem [l2_pkg::N_WAYS][SETS];
    l2_pkg::line_state_t state_mem [l2_pkg::N_WAYS][SETS];
    l2_pkg::line_t       line_mem [l2_pkg::N_WAYS][SETS];

    logic [SET_BITS-1:0] sweep_cnt_q;
    logic                init_done_q;

    assign init_done_o = init_done_q;

    // invalidation sweep, one set per cycle
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            sweep_cnt_q <= '0;
            init_done_q <= 1'b0;
        end else if (!init_done_q) begin
            sweep_cnt_q <= sweep_cnt_q + 1'b1;
            if (&sweep_cnt_q) begin
                init_done_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!init_done_q) begin
            for (int w = 0; w < l2_pkg::N_WAYS; w++) begin
                state_mem[w][sweep_cnt_q] <= l2_pkg::LINE_INVALID;
            end
        end else if (wr_en_i) begin
            tag_mem[wr_way_i][wr_set_i]   <= wr_tag_i;
            state_mem[wr_way_i][wr_set_i] <= wr_state_i;
            line_mem[wr_way_i][wr_set_i]  <= wr_line_i;
        end
    end

    // state reads only after the sweep so lookup never sees unwritten state
    always_ff @(posedge clk) begin
        for (int w = 0; w < l2_pkg::N_WAYS; w++) begin
            if (!rst_n_i) begin
                rd_state_o[w] <= l2_pkg::LINE_INVALID;
            end else if (init_done_q) begin
                rd_state_o[w] <= state_mem[w][rd_set_i];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < l2_pkg::N_WAYS; w++) begin
            rd_tag_o[w]  <= tag_mem[w][rd_set_i];
            rd_line_o[w] <= line_mem[w][rd_set_i];
        end
    end

endmodule

`default_nettype wire

// File: hdl/l2_lookup.sv
// ************************************************************************
// L2 tag lookup and victim choice
// ************************************************************************

`timescale 1ns/100ps
`default_nettype none

module l2_lookup #(
    parameter int SET_BITS = 4,
    localparam int TAG_W = l2_pkg::ADDR_W - SET_BITS - l2_pkg::OFFSET_BITS
) (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic [SET_BITS-1:0] req_set_i,
    input  logic [TAG_W-1:0]    req_tag_i,
    input  logic [TAG_W-1:0]    rd_tag_i [l2_pkg::N_WAYS],
    input  l2_pkg::line_state_t rd_state_i [l2_pkg::N_WAYS],
    input  logic                advance_victim_i,
    output logic                tag_hit_o,
    output logic                hit_way_o,
    output logic                victim_way_o
);

    logic [l2_pkg::N_WAYS-1:0] way_hit;

    // round-robin pointer, one bit per set
    logic [2**SET_BITS-1:0] rr_q;

    always_comb begin
        for (int w = 0; w < l2_pkg::N_WAYS; w++) begin
            way_hit[w] = (rd_state_i[w] != l2_pkg::LINE_INVALID) && (rd_tag_i[w] == req_tag_i);
        end
    end

    assign tag_hit_o = |way_hit;
    assign hit_way_o = way_hit[1];

    // empty way first
    always_comb begin
        if (rd_state_i[0] == l2_pkg::LINE_INVALID) begin
            victim_way_o = 1'b0;
        end else if (rd_state_i[1] == l2_pkg::LINE_INVALID) begin
            victim_way_o = 1'b1;
        end else begin
            victim_way_o = rr_q[req_set_i];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rr_q <= '0;
        end else if (advance_victim_i) begin
            rr_q[req_set_i] <= !rr_q[req_set_i];
        end
    end

    // a fill always replaces the victim, so a tag lives in at most one way
    single_hit_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(way_hit[0] && way_hit[1]));

endmodule

`default_nettype wire

// File: hdl/l2_fsm.sv
// ************************************************************************
// L2 controller FSM
// ************************************************************************

`timescale 1ns/100ps
`default_nettype none

module l2_fsm #(
    parameter int SET_BITS = 4,
    localparam int TAG_W = l2_pkg::ADDR_W - SET_BITS - l2_pkg::OFFSET_BITS
) (
    input  logic                             clk,
    input  logic                             rst_n_i,
    input  logic                             cpu_req_i,
    input  logic                             decode_valid_i,
    input  logic                             init_done_i,
    input  l2_pkg::cpu_op_t                  req_op_i,
    input  logic [TAG_W-1:0]                 req_tag_i,
    input  logic [SET_BITS-1:0]              req_set_i,
    input  logic [l2_pkg::WORD_OFF_BITS-1:0] req_woff_i,
    input  l2_pkg::word_t                    req_wdata_i,
    input  logic                             tag_hit_i,
    input  logic                             hit_way_i,
    input  logic                             victim_way_i,
    input  logic [TAG_W-1:0]                 rd_tag_i [l2_pkg::N_WAYS],
    input  l2_pkg::line_state_t              rd_state_i [l2_pkg::N_WAYS],
    input  l2_pkg::line_t                    rd_line_i [l2_pkg::N_WAYS],
    input  logic                             mem_ack_i,
    input  l2_pkg::line_t                    mem_rdata_i,
    output logic                             busy_o,
    output logic                             cpu_ack_o,
    output l2_pkg::word_t                    cpu_rdata_o,
    output logic                             mem_req_o,
    output l2_pkg::mem_op_t                  mem_op_o,
    output l2_pkg::addr_t                    mem_addr_o,
    output l2_pkg::line_t                    mem_wdata_o,
    output logic                             wr_en_o,
    output logic                             wr_way_o,
    output logic [SET_BITS-1:0]              wr_set_o,
    output logic [TAG_W-1:0]                 wr_tag_o,
    output l2_pkg::line_state_t              wr_state_o,
    output l2_pkg::line_t                    wr_line_o,
    output logic                             advance_victim_o
);

    l2_pkg::l2_fsm_state_t state_q;
    l2_pkg::l2_fsm_state_t state_d;

    logic                  fill_q;
    logic                  way_q;
    logic [TAG_W-1:0]      vtag_q;
    l2_pkg::line_t         line_q;
    l2_pkg::line_t         merged_line;
    l2_pkg::word_t         rdata_q;
    logic                  is_wb;

    always_comb begin
        state_d = state_q;
        case (state_q)
            l2_pkg::ST_IDLE: begin
                if (decode_valid_i) state_d = l2_pkg::ST_LOOKUP;
            end
            l2_pkg::ST_LOOKUP: begin
                if (tag_hit_i) begin
                    state_d = l2_pkg::ST_HIT;
                end else if (rd_state_i[victim_way_i] == l2_pkg::LINE_DIRTY) begin
                    state_d = l2_pkg::ST_WB_REQ;
                end else begin
                    state_d = l2_pkg::ST_FILL_REQ;
                end
            end
            l2_pkg::ST_WB_REQ: begin
                if (mem_ack_i) state_d = l2_pkg::ST_WB_WAIT;
            end
            l2_pkg::ST_WB_WAIT: begin
                if (!mem_ack_i) state_d = l2_pkg::ST_FILL_REQ;
            end
            l2_pkg::ST_FILL_REQ: begin
                if (mem_ack_i) state_d = l2_pkg::ST_FILL_WAIT;
            end
            l2_pkg::ST_FILL_WAIT: begin
                if (!mem_ack_i) state_d = l2_pkg::ST_HIT;
            end
            l2_pkg::ST_HIT:      state_d = l2_pkg::ST_ACK;
            l2_pkg::ST_ACK: begin
                if (!cpu_req_i) state_d = l2_pkg::ST_ACK_WAIT;
            end
            l2_pkg::ST_ACK_WAIT: state_d = l2_pkg::ST_IDLE;
            default:             state_d = l2_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= l2_pkg::ST_IDLE;
            fill_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == l2_pkg::ST_LOOKUP) fill_q <= !tag_hit_i;
        end
    end

    // working copy of the line, later replaced by fill data on a miss
    always_ff @(posedge clk) begin
        if (state_q == l2_pkg::ST_LOOKUP) begin
            way_q  <= tag_hit_i ? hit_way_i : victim_way_i;
            line_q <= tag_hit_i ? rd_line_i[hit_way_i] : rd_line_i[victim_way_i];
            vtag_q <= rd_tag_i[victim_way_i];
        end else if (state_q == l2_pkg::ST_FILL_REQ && mem_ack_i) begin
            line_q <= mem_rdata_i;
        end
        if (state_q == l2_pkg::ST_HIT) rdata_q <= merged_line[req_woff_i];
    end

    always_comb begin
        merged_line = line_q;
        if (req_op_i == l2_pkg::OP_WRITE) merged_line[req_woff_i] = req_wdata_i;
    end

    assign busy_o      = (state_q != l2_pkg::ST_IDLE) || !init_done_i;
    assign cpu_ack_o   = (state_q == l2_pkg::ST_ACK);
    assign cpu_rdata_o = rdata_q;

    assign is_wb       = (state_q == l2_pkg::ST_WB_REQ) || (state_q == l2_pkg::ST_WB_WAIT);
    assign mem_req_o   = (state_q == l2_pkg::ST_WB_REQ) || (state_q == l2_pkg::ST_FILL_REQ);
    assign mem_op_o    = is_wb ? l2_pkg::MEM_WRITEBACK : l2_pkg::MEM_FILL;
    // victim address rebuilt from its stored tag
    assign mem_addr_o  = {is_wb ? vtag_q : req_tag_i, req_set_i,
                          {l2_pkg::OFFSET_BITS{1'b0}}};
    assign mem_wdata_o = line_q;

    assign advance_victim_o = (state_q == l2_pkg::ST_FILL_REQ) && mem_ack_i;

    assign wr_en_o    = (state_q == l2_pkg::ST_HIT) && (fill_q || req_op_i == l2_pkg::OP_WRITE);
    assign wr_way_o   = way_q;
    assign wr_set_o   = req_set_i;
    assign wr_tag_o   = req_tag_i;
    assign wr_state_o = (req_op_i == l2_pkg::OP_WRITE) ? l2_pkg::LINE_DIRTY : l2_pkg::LINE_CLEAN;
    assign wr_line_o  = merged_line;

    // a new memory request waits for the previous ack to clear
    mem_req_rise_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(mem_req_o) |-> !mem_ack_i);

endmodule

`default_nettype wire

// File: hdl/l2_core.sv
// ************************************************************************
// L2 cache core
// ************************************************************************

`timescale 1ns/100ps
`default_nettype none

module l2_core #(
    parameter int SET_BITS = 4
) (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            cpu_req_i,
    input  l2_pkg::cpu_op_t cpu_op_i,
    input  l2_pkg::addr_t   cpu_addr_i,
    input  l2_pkg::word_t   cpu_wdata_i,
    input  logic            mem_ack_i,
    input  l2_pkg::line_t   mem_rdata_i,
    output logic            cpu_ack_o,
    output l2_pkg::word_t   cpu_rdata_o,
    output logic            mem_req_o,
    output l2_pkg::mem_op_t mem_op_o,
    output l2_pkg::addr_t   mem_addr_o,
    output l2_pkg::line_t   mem_wdata_o
);

    localparam int TAG_W = l2_pkg::ADDR_W - SET_BITS - l2_pkg::OFFSET_BITS;

    // decoded request
    logic                             decode_valid;
    l2_pkg::cpu_op_t                  req_op;
    logic [TAG_W-1:0]                 req_tag;
    logic [SET_BITS-1:0]              req_set;
    logic [l2_pkg::WORD_OFF_BITS-1:0] req_woff;
    l2_pkg::word_t                    req_wdata;
    logic                             busy;

    // array ports
    logic [TAG_W-1:0]    rd_tag [l2_pkg::N_WAYS];
    l2_pkg::line_state_t rd_state [l2_pkg::N_WAYS];
    l2_pkg::line_t       rd_line [l2_pkg::N_WAYS];
    logic                init_done;
    logic                wr_en;
    logic                wr_way;
    logic [SET_BITS-1:0] wr_set;
    logic [TAG_W-1:0]    wr_tag;
    l2_pkg::line_state_t wr_state;
    l2_pkg::line_t       wr_line;

    // lookup results
    logic tag_hit;
    logic hit_way;
    logic victim_way;
    logic advance_victim;

    l2_input_decoder #(.SET_BITS(SET_BITS)) decode_u (
        .clk, .rst_n_i, .cpu_req_i, .cpu_op_i, .cpu_addr_i, .cpu_wdata_i,
        .busy_i(busy), .decode_valid_o(decode_valid), .req_op_o(req_op),
        .req_tag_o(req_tag), .req_set_o(req_set), .req_woff_o(req_woff),
        .req_wdata_o(req_wdata)
    );

    l2_localmem #(.SET_BITS(SET_BITS)) localmem_u (
        .clk, .rst_n_i, .rd_set_i(req_set), .wr_en_i(wr_en), .wr_way_i(wr_way),
        .wr_set_i(wr_set), .wr_tag_i(wr_tag), .wr_state_i(wr_state), .wr_line_i(wr_line),
        .rd_tag_o(rd_tag), .rd_state_o(rd_state), .rd_line_o(rd_line),
        .init_done_o(init_done)
    );

    l2_lookup #(.SET_BITS(SET_BITS)) lookup_u (
        .clk, .rst_n_i, .req_set_i(req_set), .req_tag_i(req_tag), .rd_tag_i(rd_tag),
        .rd_state_i(rd_state), .advance_victim_i(advance_victim), .tag_hit_o(tag_hit),
        .hit_way_o(hit_way), .victim_way_o(victim_way)
    );

    l2_fsm #(.SET_BITS(SET_BITS)) fsm_u (
        .clk, .rst_n_i, .cpu_req_i, .decode_valid_i(decode_valid), .init_done_i(init_done),
        .req_op_i(req_op), .req_tag_i(req_tag), .req_set_i(req_set), .req_woff_i(req_woff),
        .req_wdata_i(req_wdata), .tag_hit_i(tag_hit), .hit_way_i(hit_way),
        .victim_way_i(victim_way), .rd_tag_i(rd_tag), .rd_state_i(rd_state),
        .rd_line_i(rd_line), .mem_ack_i, .mem_rdata_i, .busy_o(busy), .cpu_ack_o,
        .cpu_rdata_o, .mem_req_o, .mem_op_o, .mem_addr_o, .mem_wdata_o, .wr_en_o(wr_en),
        .wr_way_o(wr_way), .wr_set_o(wr_set), .wr_tag_o(wr_tag), .wr_state_o(wr_state),
        .wr_line_o(wr_line), .advance_victim_o(advance_victim)
    );

endmodule

`default_nettype wire

// File: verification/l2_mem_model.sv
// ************************************************************************
// L2 testbench line memory
// ************************************************************************

`timescale 1ns/100ps
`default_nettype none

module l2_mem_model #(
    parameter int LATENCY = 2
) (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            mem_req_i,
    input  l2_pkg::mem_op_t mem_op_i,
    input  l2_pkg::addr_t   mem_addr_i,
    input  l2_pkg::line_t   mem_wdata_i,
    output logic            mem_ack_o,
    output l2_pkg::line_t   mem_rdata_o
);

    // only lines that were written back are stored
    l2_pkg::line_t lines [l2_pkg::addr_t];
    int unsigned   wait_cnt;

    function automatic l2_pkg::word_t pattern_word(input l2_pkg::addr_t a);
        return {a[15:0], a[31:16]} ^ 32'h5a3c_96e1;
    endfunction

    function automatic l2_pkg::line_t read_line(input l2_pkg::addr_t base);
        l2_pkg::line_t l;
        if (lines.exists(base)) begin
            l = lines[base];
        end else begin
            for (int w = 0; w < l2_pkg::WORDS_PER_LINE; w++) begin
                l[w] = pattern_word(base + 4 * w);
            end
        end
        return l;
    endfunction

    initial begin
        mem_ack_o   = 1'b0;
        mem_rdata_o = '0;
        wait_cnt    = 0;
    end

    always @(posedge clk) begin
        if (!rst_n_i) begin
            mem_ack_o <= 1'b0;
            wait_cnt  <= 0;
        end else if (mem_ack_o) begin
            if (!mem_req_i) begin
                mem_ack_o <= 1'b0;
            end
        end else if (mem_req_i) begin
            if (wait_cnt < LATENCY) begin
                wait_cnt <= wait_cnt + 1;
            end else begin
                wait_cnt  <= 0;
                mem_ack_o <= 1'b1;
                if (mem_op_i == l2_pkg::MEM_WRITEBACK) begin
                    lines[mem_addr_i] = mem_wdata_i;
                end else begin
                    mem_rdata_o <= read_line(mem_addr_i);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verification/l2_core_tb.sv
// ************************************************************************
// L2 cache core testbench
// ************************************************************************

`timescale 1ns/100ps
`default_nettype none

module l2_core_tb;

    localparam int SET_BITS     = 4;
    localparam int SETS         = 2 ** SET_BITS;
    localparam int SWEEP_CYCLES = SETS;
    localparam int HIT_LATENCY  = 3;
    localparam int OP_TIMEOUT   = 150;
    localparam int N_TABLE      = 12;
    localparam int N_RANDOM     = 40;
    localparam int WATCHDOG_CYCLES = (N_TABLE + N_RANDOM) * 200 + SWEEP_CYCLES + 4;

    logic            clk;
    logic            rst_n_i;
    logic            cpu_req_i;
    l2_pkg::cpu_op_t cpu_op_i;
    l2_pkg::addr_t   cpu_addr_i;
    l2_pkg::word_t   cpu_wdata_i;
    logic            mem_ack_i;
    l2_pkg::line_t   mem_rdata_i;
    logic            cpu_ack_o;
    l2_pkg::word_t   cpu_rdata_o;
    logic            mem_req_o;
    l2_pkg::mem_op_t mem_op_o;
    l2_pkg::addr_t   mem_addr_o;
    l2_pkg::line_t   mem_wdata_o;

    // each entry holds write flag, address, write data and memory transaction count
    logic [66:0] stim_table [N_TABLE] = '{
        {1'b0, 32'h0000_0030, 32'h0000_0000, 2'd1},
        {1'b1, 32'h0000_0034, 32'hcafe_0001, 2'd0},
        {1'b0, 32'h0000_0034, 32'h0000_0000, 2'd0},
        {1'b0, 32'h0000_1038, 32'h0000_0000, 2'd1},
        {1'b0, 32'h0000_203c, 32'h0000_0000, 2'd2},
        {1'b0, 32'h0000_0034, 32'h0000_0000, 2'd1},
        {1'b0, 32'h0000_1030, 32'h0000_0000, 2'd1},
        {1'b1, 32'h0000_0054, 32'h1234_abcd, 2'd1},
        {1'b0, 32'h0000_0054, 32'h0000_0000, 2'd0},
        {1'b1, 32'h0000_1034, 32'h0bad_f00d, 2'd0},
        {1'b0, 32'h0000_2030, 32'h0000_0000, 2'd1},
        {1'b0, 32'h0000_3030, 32'h0000_0000, 2'd2}
    };

    // reference cache and memory image
    l2_pkg::addr_t       ref_base [2][SETS];
    l2_pkg::line_state_t ref_state [2][SETS];
    l2_pkg::line_t       ref_line [2][SETS];
    logic                ref_rr [SETS];
    l2_pkg::line_t       ref_mem [l2_pkg::addr_t];

    l2_pkg::mem_op_t exp_op [$];
    l2_pkg::addr_t   exp_addr [$];
    l2_pkg::line_t   exp_data [$];
    l2_pkg::mem_op_t obs_op [$];
    l2_pkg::addr_t   obs_addr [$];
    l2_pkg::line_t   obs_data [$];

    int errors;
    int tests_failed;

    l2_core #(.SET_BITS(SET_BITS)) l2_core_inst (
        .clk(clk), .rst_n_i(rst_n_i), .cpu_req_i(cpu_req_i), .cpu_op_i(cpu_op_i),
        .cpu_addr_i(cpu_addr_i), .cpu_wdata_i(cpu_wdata_i), .mem_ack_i(mem_ack_i),
        .mem_rdata_i(mem_rdata_i), .cpu_ack_o(cpu_ack_o), .cpu_rdata_o(cpu_rdata_o),
        .mem_req_o(mem_req_o), .mem_op_o(mem_op_o), .mem_addr_o(mem_addr_o),
        .mem_wdata_o(mem_wdata_o)
    );

    l2_mem_model #(.LATENCY(2)) mem_u (
        .clk(clk), .rst_n_i(rst_n_i), .mem_req_i(mem_req_o), .mem_op_i(mem_op_o),
        .mem_addr_i(mem_addr_o), .mem_wdata_i(mem_wdata_o), .mem_ack_o(mem_ack_i),
        .mem_rdata_o(mem_rdata_i)
    );

    always #10 clk = ~clk;

    // req and ack overlap for one cycle in each handshake
    always @(negedge clk) begin
        if (rst_n_i && mem_req_o && mem_ack_i) begin
            obs_op.push_back(mem_op_o);
            obs_addr.push_back(mem_addr_o);
            obs_data.push_back(mem_wdata_o);
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic l2_pkg::line_t memory_line(input l2_pkg::addr_t base);
        l2_pkg::line_t l;
        if (ref_mem.exists(base)) begin
            l = ref_mem[base];
        end else begin
            for (int w = 0; w < 4; w++) begin
                l[w] = {base[15:0] + 16'(4 * w), base[31:16]} ^ 32'h5a3c_96e1;
            end
        end
        return l;
    endfunction

    task automatic model_access(input l2_pkg::cpu_op_t op, input l2_pkg::addr_t addr,
                                input l2_pkg::word_t wdata, output l2_pkg::word_t rdata,
                                output logic hit);
        l2_pkg::addr_t base;
        int            set;
        int            way;
        base = addr & ~32'hf;
        set  = addr[4 +: SET_BITS];
        hit  = 1'b0;
        way  = 0;
        for (int w = 0; w < 2; w++) begin
            if (ref_state[w][set] != l2_pkg::LINE_INVALID && ref_base[w][set] == base) begin
                hit = 1'b1;
                way = w;
            end
        end
        if (!hit) begin
            if (ref_state[0][set] == l2_pkg::LINE_INVALID) begin
                way = 0;
            end else if (ref_state[1][set] == l2_pkg::LINE_INVALID) begin
                way = 1;
            end else begin
                way = ref_rr[set];
            end
            if (ref_state[way][set] == l2_pkg::LINE_DIRTY) begin
                exp_op.push_back(l2_pkg::MEM_WRITEBACK);
                exp_addr.push_back(ref_base[way][set]);
                exp_data.push_back(ref_line[way][set]);
                ref_mem[ref_base[way][set]] = ref_line[way][set];
            end
            exp_op.push_back(l2_pkg::MEM_FILL);
            exp_addr.push_back(base);
            exp_data.push_back('0);
            ref_line[way][set]  = memory_line(base);
            ref_base[way][set]  = base;
            ref_state[way][set] = l2_pkg::LINE_CLEAN;
            // pointer moves on every fill
            ref_rr[set] = !ref_rr[set];
        end
        if (op == l2_pkg::OP_WRITE) begin
            ref_line[way][set][addr[3:2]] = wdata;
            ref_state[way][set] = l2_pkg::LINE_DIRTY;
        end
        rdata = ref_line[way][set][addr[3:2]];
    endtask

    task automatic compare_traffic();
        if (obs_op.size() != exp_op.size()) begin
            $display("%0d memory transactions seen where the model expects %0d",
                     obs_op.size(), exp_op.size());
            errors++;
        end else begin
            for (int i = 0; i < obs_op.size(); i++) begin
                if (obs_op[i] != exp_op[i]) begin
                    $display("MISMATCH mem_op_o: got %h expected %h", obs_op[i], exp_op[i]);
                    errors++;
                end
                if (obs_addr[i] != exp_addr[i]) begin
                    $display("MISMATCH mem_addr_o: got %h expected %h", obs_addr[i], exp_addr[i]);
                    errors++;
                end
                if (exp_op[i] == l2_pkg::MEM_WRITEBACK && obs_data[i] != exp_data[i]) begin
                    $display("MISMATCH mem_wdata_o: got %h expected %h", obs_data[i], exp_data[i]);
                    errors++;
                end
            end
        end
        obs_op.delete();
        obs_addr.delete();
        obs_data.delete();
        exp_op.delete();
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic run_op(input int idx, input l2_pkg::cpu_op_t op, input l2_pkg::addr_t addr,
                          input l2_pkg::word_t wdata, input int hold, input int exp_xfers);
        l2_pkg::word_t exp_rdata;
        logic          hit;
        logic          got;
        int            cycles;
        int            nobs;
        int            errors_before;
        errors_before = errors;
        model_access(op, addr, wdata, exp_rdata, hit);
        @(posedge clk);
        cpu_req_i   <= 1'b1;
        cpu_op_i    <= op;
        cpu_addr_i  <= addr;
        cpu_wdata_i <= wdata;
        // first edge that samples req high
        @(posedge clk);
        cycles = 0;
        got    = 1'b0;
        while (!got && cycles < OP_TIMEOUT) begin
            @(negedge clk);
            if (cpu_ack_o) begin
                got = 1'b1;
            end else begin
                cycles++;
            end
        end
        if (!got) begin
            $display("no ack from the DUT within %0d cycles", OP_TIMEOUT);
            errors++;
        end else begin
            if (hit && cycles != HIT_LATENCY) begin
                $display("MISMATCH cpu_ack_o latency: got %h expected %h", cycles, HIT_LATENCY);
                errors++;
            end
            if (op == l2_pkg::OP_READ && cpu_rdata_o != exp_rdata) begin
                $display("MISMATCH cpu_rdata_o: got %h expected %h", cpu_rdata_o, exp_rdata);
                errors++;
            end
            if (idx == 0 && cycles < SWEEP_CYCLES) begin
                $display("ack came back before the reset sweep had finished");
                errors++;
            end
        end
        repeat (hold) begin
            @(negedge clk);
            if (!cpu_ack_o) begin
                $display("cpu_ack_o fell while cpu_req_i was still high");
                errors++;
            end
        end
        @(posedge clk);
        cpu_req_i <= 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (cpu_ack_o && cycles < 2);
        if (cpu_ack_o) begin
            $display("cpu_ack_o did not fall on the cycle after cpu_req_i dropped");
            errors++;
        end
        nobs = obs_op.size();
        if (exp_xfers >= 0 && nobs != exp_xfers) begin
            $display("MISMATCH memory transaction count: got %h expected %h", nobs, exp_xfers);
            errors++;
        end
        compare_traffic();
        if (errors != errors_before) begin
            tests_failed++;
        end
        $display("test %0d: %s %h %s", idx, (op == l2_pkg::OP_WRITE) ? "write" : "read ",
                 addr, (errors == errors_before) ? "ok" : "failed");
    endtask

    initial begin
        logic [31:0]     rnd;
        l2_pkg::cpu_op_t op;
        l2_pkg::addr_t   addr;
        clk          = 1'b0;
        rst_n_i      = 1'b0;
        cpu_req_i    = 1'b0;
        cpu_op_i     = l2_pkg::OP_READ;
        cpu_addr_i   = '0;
        cpu_wdata_i  = '0;
        errors       = 0;
        tests_failed = 0;
        for (int s = 0; s < SETS; s++) begin
            ref_rr[s]       = 1'b0;
            ref_state[0][s] = l2_pkg::LINE_INVALID;
            ref_state[1][s] = l2_pkg::LINE_INVALID;
        end
        repeat (4) @(posedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);
        if (mem_req_o !== 1'b0) begin
            $display("MISMATCH mem_req_o: got %h expected %h", mem_req_o, 1'b0);
            errors++;
        end
        if (cpu_ack_o !== 1'b0) begin
            $display("MISMATCH cpu_ack_o: got %h expected %h", cpu_ack_o, 1'b0);
            errors++;
        end
        // the first request goes out while the sweep is still running
        for (int i = 0; i < N_TABLE; i++) begin
            op = stim_table[i][66] ? l2_pkg::OP_WRITE : l2_pkg::OP_READ;
            run_op(i, op, stim_table[i][65:34], stim_table[i][33:2], i % 3,
                   int'(stim_table[i][1:0]));
        end
        // two sets with four tags each keep the ways conflicting
        rnd = 32'hdc18_5346;
        for (int i = 0; i < N_RANDOM; i++) begin
            rnd  = xorshift(rnd);
            op   = rnd[31] ? l2_pkg::OP_WRITE : l2_pkg::OP_READ;
            addr = rnd & 32'h0000_031c;
            rnd  = xorshift(rnd);
            run_op(N_TABLE + i, op, addr, rnd, i % 2, -1);
        end
        $display("%0d tests, %0d failed, %0d errors", N_TABLE + N_RANDOM, tests_failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
hdl/l2_pkg.sv
hdl/l2_input_decoder.sv
hdl/l2_localmem.sv
hdl/l2_lookup.sv
hdl/l2_fsm.sv
hdl/l2_core.sv
verification/l2_mem_model.sv
verification/l2_core_tb.sv

// File: Bender.yml
package:
  name: l2_cache

sources:
  - hdl/l2_pkg.sv
  - hdl/l2_input_decoder.sv
  - hdl/l2_localmem.sv
  - hdl/l2_lookup.sv
  - hdl/l2_fsm.sv
  - hdl/l2_core.sv
  - target: test
    files:
      - verification/l2_mem_model.sv
      - verification/l2_core_tb.sv
